// File: valu.f
+incdir+tb
common/valu_pkg.sv
design/valu_addsub.sv
mul/valu_lane_mul.sv
mul/valu_mac_reduce.sv
design/valu_ctrl.sv
design/valu_top.sv
tb/valu_tb.sv

// File: Makefile
TOP := valu_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f valu.f

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f valu.f

clean:
	rm -rf obj_dir $(LOG)

// File: tb/valu_model.svh
// reference model of the vector ALU for the testbench
// expected result for every op and SEW, and the expected completion latency

`ifndef VALU_MODEL_SVH
`define VALU_MODEL_SVH

    // sign-extend the low w bits of v to 64 bits
    function automatic longint sign_extend(logic [63:0] v, int w);
        longint t;
        t = $signed(v << (64 - w));
        return t >>> (64 - w);
    endfunction

    // op and sew use the plain 2-bit encodings 0 to 3
    function automatic logic [63:0] model_result(logic [1:0] op, logic [1:0] sew,
                                                 logic [63:0] a, logic [63:0] b);
        int          w;
        int          n;
        longint      x;
        longint      y;
        logic [63:0] mask;
        logic [63:0] lane_res;
        logic [63:0] r;
        logic [31:0] acc;
        if (sew == 2'd3) begin
            return 64'd0;
        end
        w    = 8 << sew;
        n    = 64 / w;
        mask = (64'd1 << w) - 64'd1;
        r    = 64'd0;
        acc  = 32'd0;
        for (int i = 0; i < n; i++) begin
            x = sign_extend((a >> (i * w)) & mask, w);
            y = sign_extend((b >> (i * w)) & mask, w);
            case (op)
                2'd0:    lane_res = x + y;
                2'd1:    lane_res = x - y;
                default: lane_res = x * y;
            endcase
            // every lane product fits a longint, so the low word is exact
            acc = acc + 32'(x * y);
            r   = r | ((lane_res & mask) << (i * w));
        end
        if (op == 2'd3) begin
            return {32'd0, acc};
        end
        return r;
    endfunction

    // edges from the accept edge to the edge that raises valid_out
    function automatic int model_latency(logic [1:0] op, logic [1:0] sew);
        if (sew == 2'd3 || op == 2'd0 || op == 2'd1) begin
            return 1;
        end
        if (sew == 2'd0) begin
            return 5;
        end
        return 3;
    endfunction

`endif

// File: tb/valu_tb.sv
// testbench for the vector ALU
// random requests from an LCG, stray requests while busy, checks against the model

`timescale 1ns/1ps

module valu_tb
    import valu_pkg::*;
;

    localparam int NUM_REQ        = 200;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 8 + 50;

    logic             clk;
    logic             rst_n;
    logic             valid_in;
    valu_op_e         op;
    valu_sew_e        sew;
    logic [VLEN-1:0]  vs1_data;
    logic [VLEN-1:0]  vs2_data;
    logic             ready;
    logic             valid_out;
    logic [VLEN-1:0]  result;

    logic [31:0]      rng_state;
    int               cycle_count;
    int               pulse_count;
    int               stray_count;
    int               value_errors;
    int               protocol_errors;

    `include "valu_model.svh"

    valu_top u_valu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .op        (op),
        .sew       (sew),
        .vs1_data  (vs1_data),
        .vs2_data  (vs2_data),
        .ready     (ready),
        .valid_out (valid_out),
        .result    (result)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_protocol(bit cond, string what);
        assert (cond) else begin
            protocol_errors++;
            $display("protocol violation at cycle %0d: %s", cycle_count, what);
        end
    endtask

    // random op, sew and operands onto the DUT inputs
    task automatic drive_random(logic req_valid);
        logic [31:0] r;
        r        = next_rand();
        valid_in = req_valid;
        op       = valu_op_e'(r[17:16]);
        sew      = valu_sew_e'(r[25:24]);
        vs1_data = {next_rand(), next_rand()};
        vs2_data = {next_rand(), next_rand()};
        // corner lanes now and then
        if (r[30:28] == 3'd0) begin
            vs1_data = {8{8'h80}};
        end
        if (r[30:28] == 3'd1) begin
            vs2_data = '1;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // completion pulses, sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n === 1'b1 && valid_out === 1'b1) begin
            pulse_count++;
        end
    end

    initial begin
        string        name;
        logic [63:0]  exp_res;
        int           exp_lat;
        int           edges;
        clk             = 1'b0;
        rst_n           = 1'b0;
        valid_in        = 1'b0;
        op              = OP_VADD;
        sew             = SEW_8;
        vs1_data        = '0;
        vs2_data        = '0;
        rng_state       = 32'd78;
        cycle_count     = 0;
        pulse_count     = 0;
        stray_count     = 0;
        value_errors    = 0;
        protocol_errors = 0;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset ready", 64'd1, 64'(ready));
        check_value("reset valid_out", 64'd0, 64'(valid_out));
        check_value("reset result", 64'd0, result);

        for (int idx = 0; idx < NUM_REQ; idx++) begin
            drive_random(1'b1);
            exp_res = model_result(op, sew, vs1_data, vs2_data);
            exp_lat = model_latency(op, sew);
            name    = $sformatf("%s %s #%0d", op.name(), sew.name(), idx);
            check_protocol(ready === 1'b1, "ready was low when a new request was due");

            // the next rising edge accepts the request
            @(negedge clk);
            edges = 0;
            while (valid_out !== 1'b1) begin
                check_protocol(ready === 1'b0, "ready went high with an operation in flight");
                // stray requests must be ignored while busy
                drive_random(next_rand() > 32'h7fff_ffff);
                if (valid_in) begin
                    stray_count++;
                end
                @(negedge clk);
                edges++;
            end
            valid_in = 1'b0;
            check_protocol(ready === 1'b1, "ready did not return with valid_out");
            check_value({name, " latency"}, 64'(exp_lat), 64'(edges));
            check_value({name, " result"}, exp_res, result);
        end

        repeat (4) @(negedge clk);
        check_value("valid_out pulse count", 64'(NUM_REQ), 64'(pulse_count));

        $display("requests %0d, stray requests %0d, value errors %0d, protocol errors %0d",
                 NUM_REQ, stray_count, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: design/valu_top.sv
// top level of the 64-bit vector ALU
// connects the controller, add/sub datapath, lane multiplier and MAC reducer

`timescale 1ns/1ps

module valu_top
    import valu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    input  valu_op_e         op,
    input  valu_sew_e        sew,
    input  logic [VLEN-1:0]  vs1_data,
    input  logic [VLEN-1:0]  vs2_data,
    output logic             ready,
    output logic             valid_out,
    output logic [VLEN-1:0]  result
);

    valu_req_t         req;
    logic [VLEN-1:0]   addsub_res;
    valu_prod_t        prods;
    logic              mul_start;
    logic              mul_done;
    logic [MAC_W-1:0]  mac_sum;

    valu_ctrl u_valu_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .op         (op),
        .sew        (sew),
        .vs1_data   (vs1_data),
        .vs2_data   (vs2_data),
        .addsub_res (addsub_res),
        .prods      (prods),
        .mul_done   (mul_done),
        .mac_sum    (mac_sum),
        .req        (req),
        .mul_start  (mul_start),
        .ready      (ready),
        .valid_out  (valid_out),
        .result     (result)
    );

    valu_addsub u_valu_addsub (
        .req        (req),
        .addsub_res (addsub_res)
    );

    valu_lane_mul u_valu_lane_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .mul_start (mul_start),
        .prods     (prods),
        .mul_done  (mul_done)
    );

    valu_mac_reduce u_valu_mac_reduce (
        .sew     (req.sew),
        .prods   (prods),
        .mac_sum (mac_sum)
    );

endmodule

// File: design/valu_ctrl.sv
// request-accept FSM with operand latch and result register
// selects the add/sub, VMUL or VMAC result and pulses valid_out

`timescale 1ns/1ps

module valu_ctrl
    import valu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_in,
    input  valu_op_e          op,
    input  valu_sew_e         sew,
    input  logic [VLEN-1:0]   vs1_data,
    input  logic [VLEN-1:0]   vs2_data,
    input  logic [VLEN-1:0]   addsub_res,
    input  valu_prod_t        prods,
    input  logic              mul_done,
    input  logic [MAC_W-1:0]  mac_sum,
    output valu_req_t         req,
    output logic              mul_start,
    output logic              ready,
    output logic              valid_out,
    output logic [VLEN-1:0]   result
);

    typedef enum logic [1:0] {
        IDLE,
        ADDSUB,
        MUL
    } state_e;

    state_e           state;
    logic             accept;
    logic             is_mul_path;
    logic [VLEN-1:0]  mul_packed;

    assign ready  = (state == IDLE);
    assign accept = valid_in && ready;

    // multiply path only for VMUL/VMAC with a legal element width
    assign is_mul_path = ((op == OP_VMUL) || (op == OP_VMAC)) && (sew != SEW_RSVD);

    // operands stay put until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            req <= '{op: op, sew: sew, vs1: vs1_data, vs2: vs2_data};
        end
    end

    // keep the low SEW bits of every product slot
    always_comb begin
        mul_packed = '0;
        case (req.sew)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    mul_packed[i*8 +: 8] = prods.p8[i][7:0];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    mul_packed[i*16 +: 16] = prods.p16[i][15:0];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    mul_packed[i*32 +: 32] = prods.p32[i][31:0];
                end
            end
            default: mul_packed = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            mul_start <= 1'b0;
            valid_out <= 1'b0;
            result    <= '0;
        end else begin
            valid_out <= 1'b0;
            mul_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (is_mul_path) begin
                            state     <= MUL;
                            mul_start <= 1'b1;
                        end else begin
                            state <= ADDSUB;
                        end
                    end
                end
                ADDSUB: begin
                    // reserved SEW lands here for every op, add/sub gives zero for it
                    result    <= addsub_res;
                    valid_out <= 1'b1;
                    state     <= IDLE;
                end
                MUL: begin
                    // mul_done is still stale from the last op while mul_start is high
                    if (mul_done && !mul_start) begin
                        if (req.op == OP_VMUL) begin
                            result <= mul_packed;
                        end else begin
                            result <= {{(VLEN-MAC_W){1'b0}}, mac_sum};
                        end
                        valid_out <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // one completion pulse per request, never back to back
    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |=> !valid_out);

    // an accepted request always leaves IDLE on the next cycle
    a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> !ready);

endmodule

// File: mul/valu_mac_reduce.sv
// VMAC reduction of the lane products
// sign-extends or truncates each product and sums them modulo 2^32

`timescale 1ns/1ps

module valu_mac_reduce
    import valu_pkg::*;
(
    input  valu_sew_e         sew,
    input  valu_prod_t        prods,
    output logic [MAC_W-1:0]  mac_sum
);

    always_comb begin
        mac_sum = '0;
        case (sew)
            SEW_8: begin
                // 16-bit products widened with their sign
                for (int i = 0; i < 8; i++) begin
                    mac_sum = mac_sum + {{(MAC_W-16){prods.p8[i][15]}}, prods.p8[i]};
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    mac_sum = mac_sum + prods.p16[i];
                end
            end
            SEW_32: begin
                // only the low word of each 64-bit product matters for a 32-bit sum
                for (int i = 0; i < 2; i++) begin
                    mac_sum = mac_sum + prods.p32[i][MAC_W-1:0];
                end
            end
            default: mac_sum = '0;
        endcase
    end

endmodule

// File: mul/valu_lane_mul.sv
// stepped signed lane multiplier with step counter and product registers
// SEW 8 does two lanes per step over four steps, SEW 16 two over two, SEW 32 one over two

`timescale 1ns/1ps

module valu_lane_mul
    import valu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  valu_req_t   req,
    input  logic        mul_start,
    output valu_prod_t  prods,
    output logic        mul_done
);

    logic [1:0]        step;
    logic              busy;
    logic [1:0]        last_step;
    logic [1:0]        step_idx;

    // lane views of the operands
    logic [7:0][7:0]   a8;
    logic [7:0][7:0]   b8;
    logic [3:0][15:0]  a16;
    logic [3:0][15:0]  b16;
    logic [1:0][31:0]  a32;
    logic [1:0][31:0]  b32;

    logic [2:0]        lane8_a;
    logic [2:0]        lane8_b;
    logic [1:0]        lane16_a;
    logic [1:0]        lane16_b;

    logic signed [15:0]  p8_a;
    logic signed [15:0]  p8_b;
    logic signed [31:0]  p16_a;
    logic signed [31:0]  p16_b;
    logic signed [63:0]  p32;

    assign a8  = req.vs1;
    assign b8  = req.vs2;
    assign a16 = req.vs1;
    assign b16 = req.vs2;
    assign a32 = req.vs1;
    assign b32 = req.vs2;

    always_comb begin
        case (req.sew)
            SEW_8:          last_step = 2'd3;
            SEW_16, SEW_32: last_step = 2'd1;
            default:        last_step = 2'd0;
        endcase
    end

    // step 0 is taken in the mul_start cycle
    assign step_idx = mul_start ? 2'd0 : step;

    assign lane8_a  = {step_idx, 1'b0};
    assign lane8_b  = {step_idx, 1'b1};
    assign lane16_a = {step_idx[0], 1'b0};
    assign lane16_b = {step_idx[0], 1'b1};

    assign p8_a  = $signed(a8[lane8_a]) * $signed(b8[lane8_a]);
    assign p8_b  = $signed(a8[lane8_b]) * $signed(b8[lane8_b]);
    assign p16_a = $signed(a16[lane16_a]) * $signed(b16[lane16_a]);
    assign p16_b = $signed(a16[lane16_b]) * $signed(b16[lane16_b]);
    assign p32   = $signed(a32[step_idx[0]]) * $signed(b32[step_idx[0]]);

    // step counter and done flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step     <= 2'd0;
            busy     <= 1'b0;
            mul_done <= 1'b0;
        end else if (mul_start || busy) begin
            if (step_idx == last_step) begin
                step     <= 2'd0;
                busy     <= 1'b0;
                mul_done <= 1'b1;
            end else begin
                step     <= step_idx + 2'd1;
                busy     <= 1'b1;
                mul_done <= 1'b0;
            end
        end
    end

    // product slots, each written once per operation
    always_ff @(posedge clk) begin
        if (mul_start || busy) begin
            case (req.sew)
                SEW_8: begin
                    prods.p8[lane8_a] <= p8_a;
                    prods.p8[lane8_b] <= p8_b;
                end
                SEW_16: begin
                    prods.p16[lane16_a] <= p16_a;
                    prods.p16[lane16_b] <= p16_b;
                end
                SEW_32:  prods.p32[step_idx[0]] <= p32;
                default: prods <= prods;
            endcase
        end
    end

    a_step_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (step <= last_step));

endmodule

// File: design/valu_addsub.sv
// lane-segmented wrapping add and subtract
// lane width follows the SEW of the latched request

`timescale 1ns/1ps

module valu_addsub
    import valu_pkg::*;
(
    input  valu_req_t        req,
    output logic [VLEN-1:0]  addsub_res
);

    logic is_sub;

    assign is_sub = (req.op == OP_VSUB);

    // each lane is computed on its own slice so no carry leaks across
    always_comb begin
        addsub_res = '0;
        case (req.sew)
            SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    addsub_res[i*8 +: 8] = is_sub ?
                        req.vs1[i*8 +: 8] - req.vs2[i*8 +: 8] :
                        req.vs1[i*8 +: 8] + req.vs2[i*8 +: 8];
                end
            end
            SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    addsub_res[i*16 +: 16] = is_sub ?
                        req.vs1[i*16 +: 16] - req.vs2[i*16 +: 16] :
                        req.vs1[i*16 +: 16] + req.vs2[i*16 +: 16];
                end
            end
            SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    addsub_res[i*32 +: 32] = is_sub ?
                        req.vs1[i*32 +: 32] - req.vs2[i*32 +: 32] :
                        req.vs1[i*32 +: 32] + req.vs2[i*32 +: 32];
                end
            end
            default: addsub_res = '0;
        endcase
    end

endmodule

// File: common/valu_pkg.sv
// shared widths, opcode and element-width encodings
// request struct and lane-product vector for the vector ALU

package valu_pkg;

    // vector register width
    localparam int VLEN = 64;

    // VMAC scalar result width
    localparam int MAC_W = 32;

    // full lane-product vector, every SEW fills it exactly
    localparam int PROD_W = 2 * VLEN;

    // opcode encoding
    typedef enum logic [1:0] {
        OP_VADD = 2'd0,
        OP_VSUB = 2'd1,
        OP_VMUL = 2'd2,
        OP_VMAC = 2'd3
    } valu_op_e;

    // element width encoding
    typedef enum logic [1:0] {
        SEW_8    = 2'd0,
        SEW_16   = 2'd1,
        SEW_32   = 2'd2,
        SEW_RSVD = 2'd3
    } valu_sew_e;

    // one accepted request, held for the whole operation
    typedef struct packed {
        valu_op_e          op;
        valu_sew_e         sew;
        logic [VLEN-1:0]   vs1;
        logic [VLEN-1:0]   vs2;
    } valu_req_t;

    // lane products, slot i is 2*SEW bits wide
    // three views of the same 128 bits
    typedef union packed {
        logic [7:0][15:0]  p8;
        logic [3:0][31:0]  p16;
        logic [1:0][63:0]  p32;
    } valu_prod_t;

endpackage
